// ==== rx_intf_pkg.sv ====
// Shared widths and types; ADC halves keep I in the low 16 bits and stream words are 64 bits.
`default_nettype none

package rx_intf_pkg;

    // sample path
    localparam int IQ_WIDTH     = 16;
    localparam int SAMPLE_WIDTH = 2 * IQ_WIDTH;
    localparam int ADC_WIDTH    = 2 * SAMPLE_WIDTH;
    localparam int GAIN_WIDTH   = 3;

    // packet capture
    localparam int WORD_WIDTH     = 64;
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;
    localparam int LEN_WIDTH      = 16;

    // FIFO depth must be a power of two
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH) + 1;

    typedef logic [IQ_WIDTH-1:0]       iq_t;
    // output sample is {I,Q} with I in the high half
    typedef logic [SAMPLE_WIDTH-1:0]   sample_t;
    // antenna 0 in the low half
    typedef logic [ADC_WIDTH-1:0]      adc_word_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [LEN_WIDTH-1:0]      pkt_len_t;
    typedef logic [7:0]                rate_t;
    typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;
    typedef logic [GAIN_WIDTH-1:0]     gain_t;

endpackage

`default_nettype wire

// ==== fifo_wr_if.sv ====
// Write side of the stream FIFO; one write per cycle with wr_en high and free_cnt in words.
`timescale 1ns/1ps
`default_nettype none

interface fifo_wr_if;
    import rx_intf_pkg::*;

    logic      wr_en;
    word_t     wr_data;
    logic      wr_last;
    fifo_cnt_t free_cnt;

    // framer side
    modport master (
        output wr_en,
        output wr_data,
        output wr_last,
        input  free_cnt
    );

    modport fifo (
        input  wr_en,
        input  wr_data,
        input  wr_last,
        output free_cnt
    );

endinterface

`default_nettype wire

// ==== adc_sample_sel.sv ====
// Gain wraps to 16 bits with no saturation; mute clears antenna 0 after any swap.
`timescale 1ns/1ps
`default_nettype none

module adc_sample_sel (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rx_intf_pkg::adc_word_t adc_data,
    input  logic                   adc_valid,
    input  logic                   ant_swap,
    input  logic                   mute_ant0,
    input  rx_intf_pkg::gain_t     bb_gain,
    output rx_intf_pkg::sample_t   sample0,
    output rx_intf_pkg::sample_t   sample1,
    output logic                   sample_strobe
);
    import rx_intf_pkg::*;

    adc_word_t ant_swapped;
    adc_word_t ant_sel;

    function automatic iq_t apply_gain(input iq_t value, input gain_t shift);
        return iq_t'(value << shift);
    endfunction

    // antenna halves trade places
    assign ant_swapped = ant_swap ?
        {adc_data[SAMPLE_WIDTH-1:0], adc_data[ADC_WIDTH-1:SAMPLE_WIDTH]} : adc_data;

    assign ant_sel = mute_ant0 ?
        {ant_swapped[ADC_WIDTH-1:SAMPLE_WIDTH], {SAMPLE_WIDTH{1'b0}}} : ant_swapped;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sample_strobe <= 1'b0;
        else
            sample_strobe <= adc_valid;
    end

    // reorder each antenna to {I,Q} on the way out
    always_ff @(posedge clk)
    begin
        if (adc_valid)
        begin
            sample0 <= {apply_gain(ant_sel[IQ_WIDTH-1:0], bb_gain),
                        apply_gain(ant_sel[2*IQ_WIDTH-1:IQ_WIDTH], bb_gain)};
            sample1 <= {apply_gain(ant_sel[3*IQ_WIDTH-1:2*IQ_WIDTH], bb_gain),
                        apply_gain(ant_sel[4*IQ_WIDTH-1:3*IQ_WIDTH], bb_gain)};
        end
    end

endmodule

`default_nettype wire

// ==== byte_to_word.sv ====
// pkt_len is held through the packet; bytes past pkt_len are dropped and fcs never meets a byte.
`timescale 1ns/1ps
`default_nettype none

module byte_to_word (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [7:0]            byte_in,
    input  logic                  byte_in_strobe,
    input  logic                  sig_strobe,
    input  rx_intf_pkg::pkt_len_t pkt_len,
    input  logic                  fcs_in_strobe,
    input  logic                  fcs_ok,
    output rx_intf_pkg::word_t    word_out,
    output logic                  word_strobe,
    output logic                  word_is_status
);
    import rx_intf_pkg::*;

    localparam int LANE_WIDTH = $clog2(BYTES_PER_WORD);

    pkt_len_t              byte_cnt;
    logic [15:0]           seq_num;
    word_t                 acc;
    word_t                 acc_next;
    logic [LANE_WIDTH-1:0] lane;
    logic                  byte_take;
    logic                  word_done;

    assign lane = byte_cnt[LANE_WIDTH-1:0];

    // the framer reserves space for pkt_len bytes only
    assign byte_take = byte_in_strobe && (byte_cnt < pkt_len);

    // lane 7 filled or last byte of the packet
    assign word_done = (lane == LANE_WIDTH'(BYTES_PER_WORD - 1)) ||
                       (byte_cnt == pkt_len - 1'b1);

    always_comb
    begin
        // a fresh word starts with all lanes zero
        acc_next = (lane == '0) ? '0 : acc;
        acc_next[lane*8 +: 8] = byte_in;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            byte_cnt       <= '0;
            seq_num        <= '0;
            word_strobe    <= 1'b0;
            word_is_status <= 1'b0;
        end
        else
        begin
            word_strobe    <= 1'b0;
            word_is_status <= 1'b0;

            if (sig_strobe)
                byte_cnt <= '0;
            else if (byte_take)
                byte_cnt <= byte_cnt + 1'b1;

            // sequence advances on every packet end, admitted or not
            if (fcs_in_strobe)
            begin
                seq_num        <= seq_num + 1'b1;
                word_strobe    <= 1'b1;
                word_is_status <= 1'b1;
            end
            else if (byte_take && word_done)
            begin
                word_strobe <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_take)
            acc <= acc_next;

        if (fcs_in_strobe)
            word_out <= word_t'({seq_num, 15'd0, fcs_ok});
        else if (byte_take && word_done)
            word_out <= acc_next;
    end

endmodule

`default_nettype wire

// ==== pkt_framer.sv ====
// A new valid header never arrives in the same cycle as a word strobe of the previous packet.
`timescale 1ns/1ps
`default_nettype none

module pkt_framer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sig_valid,
    input  rx_intf_pkg::pkt_len_t pkt_len,
    input  rx_intf_pkg::rate_t    pkt_rate,
    input  logic                  ht_sgi,
    input  rx_intf_pkg::word_t    word_in,
    input  logic                  word_strobe,
    input  logic                  word_is_status,
    fifo_wr_if.master             fifo,
    output logic                  rx_pkt_intr,
    output logic                  pkt_drop
);
    import rx_intf_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_DISCARD
    } state_t;

    state_t             state;
    logic [LEN_WIDTH:0] words_needed;
    logic [LEN_WIDTH:0] space_avail;
    logic               admit;
    logic               wr_en_q;
    word_t              wr_data_q;
    logic               wr_last_q;

    // header + ceil(len/8) data words + status
    assign words_needed = (({1'b0, pkt_len} + (LEN_WIDTH+1)'(BYTES_PER_WORD - 1))
                           >> $clog2(BYTES_PER_WORD)) + (LEN_WIDTH+1)'(2);

    // status write of the previous packet may still be in flight
    assign space_avail = (LEN_WIDTH+1)'(fifo.free_cnt) - (LEN_WIDTH+1)'(wr_en_q);
    assign admit       = (space_avail >= words_needed);

    assign fifo.wr_en   = wr_en_q;
    assign fifo.wr_data = wr_data_q;
    assign fifo.wr_last = wr_last_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= ST_IDLE;
            wr_en_q     <= 1'b0;
            rx_pkt_intr <= 1'b0;
            pkt_drop    <= 1'b0;
        end
        else
        begin
            wr_en_q     <= 1'b0;
            rx_pkt_intr <= 1'b0;
            pkt_drop    <= 1'b0;

            if (sig_valid)
            begin
                if (admit)
                begin
                    wr_en_q <= 1'b1;
                    state   <= ST_ACCEPT;
                end
                else
                begin
                    pkt_drop <= 1'b1;
                    state    <= ST_DISCARD;
                end
            end
            else if (word_strobe)
            begin
                case (state)
                    ST_ACCEPT:
                    begin
                        wr_en_q <= 1'b1;
                        if (word_is_status)
                        begin
                            rx_pkt_intr <= 1'b1;
                            state       <= ST_IDLE;
                        end
                    end
                    // swallow words up to the status word
                    ST_DISCARD:
                    begin
                        if (word_is_status)
                            state <= ST_IDLE;
                    end
                    default:
                    begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sig_valid)
        begin
            wr_data_q <= word_t'({ht_sgi, pkt_rate, pkt_len});
            wr_last_q <= 1'b0;
        end
        else if (word_strobe)
        begin
            wr_data_q <= word_in;
            wr_last_q <= word_is_status;
        end
    end

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
// DEPTH must be a power of two; writes to a full FIFO are ignored.
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int DEPTH = rx_intf_pkg::FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               arst_n,
    fifo_wr_if.fifo            wr,
    output logic               m_axis_tvalid,
    output rx_intf_pkg::word_t m_axis_tdata,
    output logic               m_axis_tlast,
    input  logic               m_axis_tready
);
    import rx_intf_pkg::*;

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    word_t                 mem_data [DEPTH];
    logic                  mem_last [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   level;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr.wr_en && (level != (ADDR_WIDTH+1)'(DEPTH));
    assign do_rd = m_axis_tvalid && m_axis_tready;

    // first word falls through to the stream port
    assign m_axis_tvalid = (level != '0);
    assign m_axis_tdata  = mem_data[rd_ptr];
    assign m_axis_tlast  = mem_last[rd_ptr];

    assign wr.free_cnt = fifo_cnt_t'((ADDR_WIDTH+1)'(DEPTH) - level);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            // pointers wrap on their own
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            level <= level + do_wr - do_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem_data[wr_ptr] <= wr.wr_data;
            mem_last[wr_ptr] <= wr.wr_last;
        end
    end

endmodule

`default_nettype wire

// ==== rx_intf.sv ====
// Single clock for ADC and demodulator; config inputs are static levels and the demodulator never stalls.
`timescale 1ns/1ps
`default_nettype none

module rx_intf (
    input  logic                   clk,
    input  logic                   arst_n,

    // ADC side
    input  rx_intf_pkg::adc_word_t adc_data,
    input  logic                   adc_valid,
    input  logic                   ant_swap,
    input  logic                   mute_ant0,
    input  rx_intf_pkg::gain_t     bb_gain,

    // to demodulator
    output rx_intf_pkg::sample_t   sample0,
    output rx_intf_pkg::sample_t   sample1,
    output logic                   sample_strobe,

    // from demodulator
    input  logic                   pkt_header_valid,
    input  logic                   pkt_header_valid_strobe,
    input  rx_intf_pkg::rate_t     pkt_rate,
    input  rx_intf_pkg::pkt_len_t  pkt_len,
    input  logic                   ht_sgi,
    input  logic [7:0]             byte_in,
    input  logic                   byte_in_strobe,
    input  logic                   fcs_in_strobe,
    input  logic                   fcs_ok,

    output logic                   rx_pkt_intr,
    output logic                   pkt_drop,

    // AXI-Stream master
    output logic                   m_axis_tvalid,
    output rx_intf_pkg::word_t     m_axis_tdata,
    output logic                   m_axis_tlast,
    input  logic                   m_axis_tready
);
    import rx_intf_pkg::*;

    logic  sig_valid;
    word_t word;
    logic  word_strobe;
    logic  word_is_status;

    fifo_wr_if wr_bus ();

    // invalid headers are ignored by the framer
    assign sig_valid = pkt_header_valid_strobe & pkt_header_valid;

    adc_sample_sel adc_sample_sel_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .ant_swap      (ant_swap),
        .mute_ant0     (mute_ant0),
        .bb_gain       (bb_gain),
        .sample0       (sample0),
        .sample1       (sample1),
        .sample_strobe (sample_strobe)
    );

    byte_to_word byte_to_word_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .byte_in        (byte_in),
        .byte_in_strobe (byte_in_strobe),
        .sig_strobe     (pkt_header_valid_strobe),
        .pkt_len        (pkt_len),
        .fcs_in_strobe  (fcs_in_strobe),
        .fcs_ok         (fcs_ok),
        .word_out       (word),
        .word_strobe    (word_strobe),
        .word_is_status (word_is_status)
    );

    pkt_framer pkt_framer_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .sig_valid      (sig_valid),
        .pkt_len        (pkt_len),
        .pkt_rate       (pkt_rate),
        .ht_sgi         (ht_sgi),
        .word_in        (word),
        .word_strobe    (word_strobe),
        .word_is_status (word_is_status),
        .fifo           (wr_bus.master),
        .rx_pkt_intr    (rx_pkt_intr),
        .pkt_drop       (pkt_drop)
    );

    stream_fifo stream_fifo_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (wr_bus.fifo),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

endmodule

`default_nettype wire

// ==== rx_intf_props.sv ====
// Bound into rx_intf; the hold rule applies only outside reset.
`timescale 1ns/1ps
`default_nettype none

module rx_intf_props (
    input logic               clk,
    input logic               arst_n,
    input logic               m_axis_tvalid,
    input rx_intf_pkg::word_t m_axis_tdata,
    input logic               m_axis_tlast,
    input logic               m_axis_tready,
    input logic               rx_pkt_intr,
    input logic               pkt_drop
);

    int assert_errors = 0;

    // stalled word stays on the bus unchanged
    stream_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (m_axis_tvalid && !m_axis_tready) |=>
        (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
        else
        begin
            assert_errors++;
            $error("stream word changed or vanished while tready was low");
        end

    intr_drop_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(rx_pkt_intr && pkt_drop))
        else
        begin
            assert_errors++;
            $error("rx_pkt_intr and pkt_drop high in the same cycle");
        end

    tvalid_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !m_axis_tvalid)
        else
        begin
            assert_errors++;
            $error("tvalid high in the first cycle after reset");
        end

endmodule

bind rx_intf rx_intf_props props_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .rx_pkt_intr   (rx_pkt_intr),
    .pkt_drop      (pkt_drop)
);

`default_nettype wire

// ==== tb_rx_intf.sv ====
// Directed tests on one clock; pkt_len stays at 100 bytes or fewer so one packet fits an empty FIFO.
`timescale 1ns/1ps
`default_nettype none

module tb_rx_intf;
    import rx_intf_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_PKTS     = 13;
    localparam int MAX_LEN      = 100;
    // reset, 32 sample checks, then packets at up to two cycles per byte under back-pressure
    localparam int MAX_CYCLES   = 3 * (RESET_CYCLES + 2 * 32 + NUM_PKTS * (2 * MAX_LEN + 40));

    localparam logic [1:0] READY_HIGH = 2'd0;
    localparam logic [1:0] READY_LOW  = 2'd1;
    localparam logic [1:0] READY_RAND = 2'd2;

    logic      clk;
    logic      arst_n;
    adc_word_t adc_data;
    logic      adc_valid;
    logic      ant_swap;
    logic      mute_ant0;
    gain_t     bb_gain;
    sample_t   sample0;
    sample_t   sample1;
    logic      sample_strobe;
    logic      pkt_header_valid;
    logic      pkt_header_valid_strobe;
    rate_t     pkt_rate;
    pkt_len_t  pkt_len;
    logic      ht_sgi;
    logic [7:0] byte_in;
    logic      byte_in_strobe;
    logic      fcs_in_strobe;
    logic      fcs_ok;
    logic      rx_pkt_intr;
    logic      pkt_drop;
    logic      m_axis_tvalid;
    word_t     m_axis_tdata;
    logic      m_axis_tlast;
    logic      m_axis_tready;

    integer     seed = 32'h6d96;
    int         cycle_cnt = 0;
    int         value_errors = 0;
    int         other_errors = 0;
    logic [1:0] ready_mode;
    logic [15:0] seq_cnt = '0;

    word_t exp_data [$];
    logic  exp_last [$];
    word_t got_data [$];
    logic  got_last [$];

    rx_intf dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: DUT stream did not complete within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    always @(posedge clk)
    begin : ready_drive
        integer r;
        r = $random(seed);
        case (ready_mode)
            READY_LOW:  m_axis_tready <= 1'b0;
            READY_RAND: m_axis_tready <= r[0];
            default:    m_axis_tready <= 1'b1;
        endcase
    end

    // a word seen here transfers on the next rising edge
    always @(negedge clk)
    begin
        if (arst_n && m_axis_tvalid && m_axis_tready)
        begin
            got_data.push_back(m_axis_tdata);
            got_last.push_back(m_axis_tlast);
        end
    end

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic iq_t shift_iq(input iq_t x, input gain_t g);
        logic [31:0] wide;
        wide = {16'd0, x} << g;
        return wide[15:0];
    endfunction

    task automatic expect_word(input word_t w, input logic last);
        exp_data.push_back(w);
        exp_last.push_back(last);
    endtask

    task automatic wait_for_stream();
        while (got_data.size() < exp_data.size())
            @(negedge clk);
    endtask

    task automatic drain_and_compare();
        int n;
        wait_for_stream();
        repeat (10) @(negedge clk);
        if (got_data.size() != exp_data.size())
        begin
            other_errors++;
            $display("stream carried %0d words where %0d were expected",
                     got_data.size(), exp_data.size());
        end
        n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
        for (int i = 0; i < n; i++)
        begin
            check_word("m_axis_tdata", got_data[i], exp_data[i]);
            check_bit("m_axis_tlast", got_last[i], exp_last[i]);
        end
        got_data.delete();
        got_last.delete();
        exp_data.delete();
        exp_last.delete();
    endtask

    task automatic send_packet(input pkt_len_t len, input rate_t rate, input logic sgi,
                               input logic good_fcs, input logic hdr_valid, input logic fits);
        logic [7:0] bytes [$];
        logic [7:0] b;
        word_t      w;
        for (int k = 0; k < len; k++)
        begin
            b = $random(seed);
            bytes.push_back(b);
        end
        // header, data lanes from the low bits up, then status with tlast
        if (hdr_valid && fits)
        begin
            w = '0;
            w[15:0]  = len;
            w[23:16] = rate;
            w[24]    = sgi;
            expect_word(w, 1'b0);
            w = '0;
            for (int k = 0; k < len; k++)
            begin
                w[(k % 8) * 8 +: 8] = bytes[k];
                if ((k % 8 == 7) || (k == len - 1))
                begin
                    expect_word(w, 1'b0);
                    w = '0;
                end
            end
            w = '0;
            w[0]     = good_fcs;
            w[31:16] = seq_cnt;
            expect_word(w, 1'b1);
        end
        @(posedge clk);
        pkt_header_valid_strobe <= 1'b1;
        pkt_header_valid        <= hdr_valid;
        pkt_len                 <= len;
        pkt_rate                <= rate;
        ht_sgi                  <= sgi;
        @(posedge clk);
        pkt_header_valid_strobe <= 1'b0;
        @(negedge clk);
        check_bit("pkt_drop", pkt_drop, hdr_valid && !fits);
        for (int k = 0; k < len; k++)
        begin
            @(posedge clk);
            byte_in        <= bytes[k];
            byte_in_strobe <= 1'b1;
        end
        @(posedge clk);
        byte_in_strobe <= 1'b0;
        repeat (3) @(posedge clk);
        if (hdr_valid)
        begin
            fcs_in_strobe <= 1'b1;
            fcs_ok        <= good_fcs;
            @(posedge clk);
            fcs_in_strobe <= 1'b0;
            @(posedge clk);
            // interrupt lines up with the status word write
            @(negedge clk);
            check_bit("rx_pkt_intr", rx_pkt_intr, fits);
            @(negedge clk);
            check_bit("rx_pkt_intr", rx_pkt_intr, 1'b0);
            seq_cnt++;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic test_sample_path();
        adc_word_t adc;
        sample_t   a0;
        sample_t   a1;
        sample_t   tmp;
        sample_t   exp0;
        sample_t   exp1;
        logic      swap;
        logic      mute;
        gain_t     g;
        for (int c = 0; c < 32; c++)
        begin
            adc  = {$random(seed), $random(seed)};
            swap = c[0];
            mute = c[1];
            g    = c[4:2];
            a0   = adc[31:0];
            a1   = adc[63:32];
            if (swap)
            begin
                tmp = a0;
                a0  = a1;
                a1  = tmp;
            end
            if (mute)
                a0 = '0;
            exp0 = {shift_iq(a0[15:0], g), shift_iq(a0[31:16], g)};
            exp1 = {shift_iq(a1[15:0], g), shift_iq(a1[31:16], g)};
            @(posedge clk);
            adc_data  <= adc;
            adc_valid <= 1'b1;
            ant_swap  <= swap;
            mute_ant0 <= mute;
            bb_gain   <= g;
            @(negedge clk);
            check_bit("sample_strobe", sample_strobe, 1'b0);
            @(posedge clk);
            adc_valid <= 1'b0;
            @(negedge clk);
            check_bit("sample_strobe", sample_strobe, 1'b1);
            check_sample("sample0", sample0, exp0);
            check_sample("sample1", sample1, exp1);
        end
    endtask

    task automatic test_single_packet();
        send_packet(16'd13, 8'h0b, 1'b0, 1'b1, 1'b1, 1'b1);
        drain_and_compare();
    endtask

    task automatic test_fcs_and_sequence();
        send_packet(16'd5, 8'h0f, 1'b1, 1'b0, 1'b1, 1'b1);
        send_packet(16'd16, 8'h80, 1'b0, 1'b1, 1'b1, 1'b1);
        send_packet(16'd21, 8'h8a, 1'b1, 1'b0, 1'b1, 1'b1);
        // invalid header must leave the stream untouched
        send_packet(16'd10, 8'h0b, 1'b0, 1'b1, 1'b0, 1'b0);
        drain_and_compare();
    endtask

    task automatic test_backpressure();
        integer   r;
        pkt_len_t len;
        @(posedge clk);
        ready_mode <= READY_RAND;
        for (int p = 0; p < 5; p++)
        begin
            r   = $random(seed);
            len = pkt_len_t'(1 + (r[6:0] % MAX_LEN));
            wait_for_stream();
            send_packet(len, rate_t'(r[15:8]), r[16], r[17], 1'b1, 1'b1);
        end
        drain_and_compare();
        @(posedge clk);
        ready_mode <= READY_HIGH;
    endtask

    task automatic test_overflow_drop();
        @(posedge clk);
        ready_mode <= READY_LOW;
        repeat (3) @(posedge clk);
        // 12 words leave 4 free, the second needs 7
        send_packet(16'd80, 8'h0d, 1'b0, 1'b1, 1'b1, 1'b1);
        send_packet(16'd40, 8'h0e, 1'b1, 1'b1, 1'b1, 1'b0);
        // first header waits at the head of the stalled stream
        @(negedge clk);
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b1);
        check_word("m_axis_tdata", m_axis_tdata, exp_data[0]);
        @(posedge clk);
        ready_mode <= READY_HIGH;
        drain_and_compare();
        send_packet(16'd8, 8'h0c, 1'b0, 1'b1, 1'b1, 1'b1);
        drain_and_compare();
    endtask

    initial
    begin
        clk                     = 1'b0;
        arst_n                  = 1'b0;
        adc_data                = '0;
        adc_valid               = 1'b0;
        ant_swap                = 1'b0;
        mute_ant0               = 1'b0;
        bb_gain                 = '0;
        pkt_header_valid        = 1'b0;
        pkt_header_valid_strobe = 1'b0;
        pkt_rate                = '0;
        pkt_len                 = '0;
        ht_sgi                  = 1'b0;
        byte_in                 = '0;
        byte_in_strobe          = 1'b0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        m_axis_tready           = 1'b1;
        ready_mode              = READY_HIGH;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        // outputs idle once out of reset
        @(negedge clk);
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_bit("sample_strobe", sample_strobe, 1'b0);
        check_bit("rx_pkt_intr", rx_pkt_intr, 1'b0);
        check_bit("pkt_drop", pkt_drop, 1'b0);
        test_sample_path();
        test_single_packet();
        test_fcs_and_sequence();
        test_backpressure();
        test_overflow_drop();
        $display("value errors: %0d, other errors: %0d, assertion errors: %0d",
                 value_errors, other_errors, dut.props_i.assert_errors);
        if (value_errors + other_errors + dut.props_i.assert_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rx_intf_pkg.sv
fifo_wr_if.sv
adc_sample_sel.sv
byte_to_word.sv
pkt_framer.sv
stream_fifo.sv
rx_intf.sv
rx_intf_props.sv
tb_rx_intf.sv
